/* logic/frontend_pkg.sv */
package frontend_pkg;

	// --------------------
	// widths with a meaning

	// a bus word, a full instruction, or a byte address
	typedef logic [31:0] word_t;

	// one 16-bit instruction parcel
	typedef logic [15:0] half_t;

	// bit 0 flags the low halfword of a word as valid, bit 1 the high one
	typedef logic [1:0] hw_mask_t;

	// counts halfwords in the assembly buffer (0 to 3)
	// or fetches in flight on the bus (0 to 2)
	typedef logic [1:0] level_t;

	// --------------------
	// sizing

	// number of prefetch queue entries
	// the fetch stall rule assumes exactly this depth
	localparam int queue_depth = 2;

endpackage

/* logic/fetch_request.sv */
`timescale 1ns/10ps

module fetch_request #(
	parameter frontend_pkg::word_t reset_vector = 32'h0000_0040
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// address phase of the fetch bus
	output frontend_pkg::word_t    mem_addr,
	output logic                   mem_addr_vld,
	input  logic                   mem_addr_rdy,
	input  logic                   mem_data_vld,
	// jump request from the core
	input  frontend_pkg::word_t    jump_target,
	input  logic                   jump_target_vld,
	output logic                   jump_target_rdy,
	output logic                   jump_now,
	// prefetch queue status
	input  logic                   queue_full,
	input  logic                   queue_almost_full,
	// qualifiers for the current data phase
	output logic                   data_live,
	output frontend_pkg::hw_mask_t data_hw_mask
);
	frontend_pkg::word_t    fetch_addr;
	logic                   mem_addr_hold;
	frontend_pkg::hw_mask_t aph_hw_mask;
	frontend_pkg::level_t   pending_fetches;
	frontend_pkg::level_t   pending_next;
	frontend_pkg::level_t   flush_pending;
	logic                   fetch_stall;

	// --------------------
	// address phase

	// a held address can not be replaced, so jumps wait for the bus
	assign jump_target_rdy = !mem_addr_hold;
	assign jump_now = jump_target_vld && jump_target_rdy;

	// stall decision uses registered counts only, so there is no path from
	// the bus ready back into the address phase
	assign fetch_stall = queue_full
		|| (queue_almost_full && |pending_fetches)
		|| pending_fetches > 2'd1;

	// a held address wins, then a jump target, then the sequential address
	always_comb begin
		mem_addr = fetch_addr;
		mem_addr_vld = 1'b1;
		if (mem_addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			mem_addr = {jump_target[31:2], 2'b00};
		end else if (fetch_stall) begin
			mem_addr_vld = 1'b0;
		end
	end

	// fetch address runs ahead of decode in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= reset_vector;
		end else if (jump_now) begin
			// step past the target when it is accepted in the same cycle
			fetch_addr <= {jump_target[31:2] + 30'(mem_addr_rdy), 2'b00};
		end else if (mem_addr_vld && mem_addr_rdy) begin
			fetch_addr <= fetch_addr + 32'd4;
		end
	end

	// --------------------
	// bus pipeline tracking

	// a fetch counts as soon as its address is first presented
	assign pending_next = pending_fetches
		+ frontend_pkg::level_t'(mem_addr_vld && !mem_addr_hold)
		- frontend_pkg::level_t'(mem_data_vld);

	// data of fetches issued before a jump is dropped here
	assign data_live = mem_data_vld && (flush_pending == 2'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_addr_hold <= 1'b0;
			pending_fetches <= 2'd0;
			flush_pending <= 2'd0;
		end else begin
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending_fetches <= pending_next;
			if (jump_now) begin
				flush_pending <= pending_fetches - frontend_pkg::level_t'(mem_data_vld);
			end else if (|flush_pending && mem_data_vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
		end
	end

	// halfword validity follows each fetch from address phase to data phase
	// so the low half of a halfword-aligned jump target's word is masked off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_hw_mask <= 2'b11;
			data_hw_mask <= 2'b11;
		end else if (jump_now) begin
			if (mem_addr_rdy) begin
				aph_hw_mask <= 2'b11;
				data_hw_mask <= {1'b1, !jump_target[1]};
			end else begin
				aph_hw_mask <= {1'b1, !jump_target[1]};
			end
		end else if (mem_addr_vld && mem_addr_rdy) begin
			data_hw_mask <= aph_hw_mask;
			aph_hw_mask <= 2'b11;
		end
	end

endmodule

/* logic/prefetch_queue.sv */
`timescale 1ns/10ps

module prefetch_queue (
	input  logic                   clk,
	input  logic                   rst_n,
	// data phase of the fetch bus
	input  frontend_pkg::word_t    mem_data,
	input  logic                   mem_data_err,
	input  frontend_pkg::hw_mask_t data_hw_mask,
	input  logic                   data_live,
	input  logic                   jump_now,
	input  logic                   room_for_fetch,
	// head of queue, or the bus word when the queue is empty
	output frontend_pkg::word_t    fetch_data,
	output logic                   fetch_err,
	output frontend_pkg::hw_mask_t fetch_hw_mask,
	output logic                   fetch_vld,
	output logic                   queue_full,
	output logic                   queue_almost_full
);
	localparam int depth = frontend_pkg::queue_depth;

	frontend_pkg::word_t    q_data [depth];
	logic                   q_err  [depth];
	frontend_pkg::hw_mask_t q_mask [depth];
	// one extra slot on top stands for the incoming bus word
	frontend_pkg::word_t    ext_data [depth + 1];
	logic                   ext_err  [depth + 1];
	frontend_pkg::hw_mask_t ext_mask [depth + 1];
	logic                   ext_vld  [depth + 1];
	logic                   below_vld [depth];
	logic                   queue_empty;
	logic                   push;
	logic                   pop;

	always_comb begin
		for (int i = 0; i < depth; i++) begin
			ext_data[i] = q_data[i];
			ext_err[i] = q_err[i];
			ext_mask[i] = q_mask[i];
			ext_vld[i] = |q_mask[i];
			// entry 0 sits on the floor, others need their lower neighbour filled
			below_vld[i] = (i == 0) ? 1'b1 : ext_vld[i - 1];
		end
		ext_data[depth] = mem_data;
		ext_err[depth] = mem_data_err;
		ext_mask[depth] = 2'b00;
		ext_vld[depth] = 1'b0;
	end

	// entries stay compact, so the fill level shows in the top valid bits
	assign queue_empty = !ext_vld[0];
	assign queue_full = ext_vld[depth - 1];
	assign queue_almost_full = ext_vld[depth - 2];

	// live data that goes straight into the CIR is not stored as well
	assign push = data_live && !(room_for_fetch && queue_empty);
	assign pop = room_for_fetch && !queue_empty;

	// payload shifts down on a pop, or lands in the first free entry on a push
	always_ff @(posedge clk) begin
		for (int i = 0; i < depth; i++) begin
			if (pop || (push && !ext_vld[i])) begin
				q_data[i] <= ext_vld[i + 1] ? ext_data[i + 1] : mem_data;
				q_err[i] <= ext_vld[i + 1] ? ext_err[i + 1] : mem_data_err;
			end
		end
	end

	// the halfword masks double as entry valid flags and a jump clears them all
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				q_mask[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < depth; i++) begin
				if (jump_now) begin
					q_mask[i] <= 2'b00;
				end else if (ext_vld[i + 1] && pop) begin
					q_mask[i] <= ext_mask[i + 1];
				end else if (ext_vld[i] && pop) begin
					q_mask[i] <= data_hw_mask & {2{push}};
				end else if (!ext_vld[i]) begin
					q_mask[i] <= (push && !pop && below_vld[i]) ? data_hw_mask : 2'b00;
				end
			end
		end
	end

	// bypass keeps a fetched word from losing a cycle in an empty queue
	assign fetch_data = queue_empty ? mem_data : q_data[0];
	assign fetch_err = queue_empty ? mem_data_err : q_err[0];
	assign fetch_hw_mask = queue_empty ? data_hw_mask : q_mask[0];
	assign fetch_vld = !queue_empty || data_live;

endmodule

/* logic/instr_assembly.sv */
`timescale 1ns/10ps

module instr_assembly (
	input  logic                   clk,
	input  logic                   rst_n,
	// word from the prefetch queue or its bypass
	input  frontend_pkg::word_t    fetch_data,
	input  logic                   fetch_err,
	input  frontend_pkg::hw_mask_t fetch_hw_mask,
	input  logic                   fetch_vld,
	input  logic                   jump_now,
	// decode side
	input  logic                   cir_flush_behind,
	input  frontend_pkg::level_t   cir_use,
	output frontend_pkg::word_t    cir,
	output frontend_pkg::level_t   cir_vld,
	output frontend_pkg::hw_mask_t cir_err,
	output logic                   room_for_fetch
);
	// spare halfword above the CIR, so a crossing 32-bit instruction can wait
	frontend_pkg::half_t          hwbuf;
	// number of valid halfwords in {hwbuf, cir}
	frontend_pkg::level_t         buf_level;
	frontend_pkg::level_t         level_no_fetch;
	frontend_pkg::level_t         fill_amount;
	frontend_pkg::level_t         level_next;
	frontend_pkg::half_t          fetch_lo;
	frontend_pkg::half_t          fetch_hi;
	frontend_pkg::half_t [2:0]    data_shifted;
	frontend_pkg::half_t [2:0]    data_next;
	logic                  [2:0]  err_reg;
	logic                  [2:0]  err_shifted;
	logic                  [2:0]  err_next;

	// --------------------
	// fetch alignment

	// when only the high half is valid it moves down into the low slot
	assign fetch_hi = fetch_data[31:16];
	assign fetch_lo = fetch_hw_mask[0] ? fetch_data[15:0] : fetch_data[31:16];

	// --------------------
	// shift out what decode consumed

	// slots above the new level are don't-care, so the cheapest value is kept
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[31:16], hwbuf};
			err_shifted = err_reg >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[31:16]};
			err_shifted = err_reg >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted = err_reg;
		end
	end

	assign level_no_fetch = buf_level - cir_use;

	// a half word fits at level 2, a whole word only at level 1 or below
	assign room_for_fetch = level_no_fetch <= (~&fetch_hw_mask ? 2'd2 : 2'd1);

	// --------------------
	// overlay the fetch word at the first free slot

	always_comb begin
		if (!room_for_fetch) begin
			data_next = data_shifted;
			err_next = err_shifted;
		end else if (level_no_fetch[1]) begin
			data_next = {fetch_lo, data_shifted[1], data_shifted[0]};
			err_next = {fetch_err, err_shifted[1:0]};
		end else if (level_no_fetch[0]) begin
			data_next = {fetch_hi, fetch_lo, data_shifted[0]};
			err_next = {{2{fetch_err}}, err_shifted[0]};
		end else begin
			data_next = {data_shifted[2], fetch_hi, fetch_lo};
			err_next = {err_shifted[2], {2{fetch_err}}};
		end
	end

	assign fill_amount = (room_for_fetch && fetch_vld) ? (&fetch_hw_mask ? 2'd2 : 2'd1) : 2'd0;

	// flush-behind keeps the oldest instruction, sized by its low two bits
	always_comb begin
		if (jump_now && cir_flush_behind) begin
			level_next = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
		end else if (jump_now) begin
			level_next = 2'd0;
		end else begin
			level_next = level_no_fetch + fill_amount;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
			err_reg <= 3'b000;
		end else begin
			buf_level <= level_next;
			// decode sees at most two halfwords, level 3 shows as 2
			cir_vld <= level_next & ~(level_next >> 1);
			err_reg <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = err_reg[1:0];

endmodule

/* logic/frontend_top.sv */
`timescale 1ns/10ps

module frontend_top #(
	parameter frontend_pkg::word_t reset_vector = 32'h0000_0040
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// fetch bus
	output frontend_pkg::word_t    mem_addr,
	output logic                   mem_addr_vld,
	input  logic                   mem_addr_rdy,
	input  frontend_pkg::word_t    mem_data,
	input  logic                   mem_data_err,
	input  logic                   mem_data_vld,
	// jump request
	input  frontend_pkg::word_t    jump_target,
	input  logic                   jump_target_vld,
	output logic                   jump_target_rdy,
	// decode
	output frontend_pkg::word_t    cir,
	output frontend_pkg::level_t   cir_vld,
	input  frontend_pkg::level_t   cir_use,
	output frontend_pkg::hw_mask_t cir_err,
	input  logic                   cir_flush_behind
);
	logic                   jump_now;
	logic                   data_live;
	frontend_pkg::hw_mask_t data_hw_mask;
	logic                   queue_full;
	logic                   queue_almost_full;
	frontend_pkg::word_t    fetch_data;
	logic                   fetch_err;
	frontend_pkg::hw_mask_t fetch_hw_mask;
	logic                   fetch_vld;
	logic                   room_for_fetch;

	// request side, owns the bus address phase and the jump handshake
	fetch_request #(
		.reset_vector(reset_vector)
	) fetch_request0 (
		.clk, .rst_n, .mem_addr, .mem_addr_vld, .mem_addr_rdy, .mem_data_vld,
		.jump_target, .jump_target_vld, .jump_target_rdy, .jump_now,
		.queue_full, .queue_almost_full, .data_live, .data_hw_mask
	);

	// two-word buffer between the bus data phase and the assembly stage
	prefetch_queue prefetch_queue0 (
		.clk, .rst_n, .mem_data, .mem_data_err, .data_hw_mask, .data_live,
		.jump_now, .room_for_fetch, .fetch_data, .fetch_err, .fetch_hw_mask,
		.fetch_vld, .queue_full, .queue_almost_full
	);

	// builds whole instructions for decode out of halfwords
	instr_assembly instr_assembly0 (
		.clk, .rst_n, .fetch_data, .fetch_err, .fetch_hw_mask, .fetch_vld,
		.jump_now, .cir_flush_behind, .cir_use, .cir, .cir_vld, .cir_err,
		.room_for_fetch
	);

endmodule

/* sim/frontend_properties.sv */
`timescale 1ns/10ps

module frontend_properties (
	input logic                 clk,
	input logic                 rst_n,
	input frontend_pkg::level_t pending_fetches,
	input frontend_pkg::level_t flush_pending,
	input logic                 mem_data_vld
);
	int fail_count = 0;

	// the stall rule stops new requests at two fetches in flight
	assert property (@(posedge clk) disable iff (!rst_n) pending_fetches <= 2'd2)
	else begin
		fail_count++;
		$error("more than two fetches outstanding");
	end

	// only fetches already in flight can be marked for discard
	assert property (@(posedge clk) disable iff (!rst_n) flush_pending <= pending_fetches)
	else begin
		fail_count++;
		$error("more fetches to discard than fetches outstanding");
	end

	// a data phase always belongs to an earlier address phase
	assert property (@(posedge clk) disable iff (!rst_n) mem_data_vld |-> pending_fetches != 2'd0)
	else begin
		fail_count++;
		$error("bus data returned with no fetch outstanding");
	end

endmodule

/* sim/frontend_tb.sv */
`timescale 1ns/10ps

module frontend_tb;

	// --------------------
	// constants

	localparam frontend_pkg::word_t reset_vector = 32'h0000_0040;
	// words from err_lo up to err_hi answer with a bus error
	localparam frontend_pkg::word_t err_lo = 32'h0000_0300;
	localparam frontend_pkg::word_t err_hi = 32'h0000_0310;
	// three times about 170 instructions at up to a dozen cycles each under waits and stalls
	localparam int cycle_limit = 6000;

	logic                   clk;
	logic                   rst_n;
	frontend_pkg::word_t    mem_addr;
	logic                   mem_addr_vld;
	logic                   mem_addr_rdy;
	frontend_pkg::word_t    mem_data;
	logic                   mem_data_err;
	logic                   mem_data_vld;
	frontend_pkg::word_t    jump_target;
	logic                   jump_target_vld;
	logic                   jump_target_rdy;
	frontend_pkg::word_t    cir;
	frontend_pkg::level_t   cir_vld;
	frontend_pkg::level_t   cir_use;
	frontend_pkg::hw_mask_t cir_err;
	logic                   cir_flush_behind;

	int errors;
	int checks;
	int prop_fails;
	int cycle_count = 0;
	logic [31:0] rng;
	// the memory model serves one data phase at a time as on AHB
	logic dphase_busy;
	frontend_pkg::word_t dphase_addr;
	int dphase_wait;
	int max_wait;
	// samples taken at the falling edge show what the DUT sees at the next rising edge
	logic s_rst;
	logic s_addr_vld;
	logic s_rdy;
	logic s_data_vld;
	frontend_pkg::word_t s_addr;
	logic held;
	frontend_pkg::word_t held_addr;
	logic got_first;
	frontend_pkg::word_t first_addr;
	// decode model
	logic decode_on;
	logic stalls_on;
	logic redirect_pending;
	frontend_pkg::word_t exp_pc;
	frontend_pkg::word_t redirect_pc;
	int consumed;

	frontend_top #(.reset_vector(reset_vector)) dut0 (.*);

	bind fetch_request frontend_properties props0 (
		.clk(clk), .rst_n(rst_n), .pending_fetches(pending_fetches),
		.flush_pending(flush_pending), .mem_data_vld(mem_data_vld)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// --------------------
	// memory image

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// the folded address sits on top so every halfword says where it came from
	function automatic frontend_pkg::half_t half_at(input frontend_pkg::word_t h);
		logic [13:0] tag;
		logic [1:0] kind;
		tag = h[14:1] ^ h[28:15] ^ {11'd0, h[31:29]};
		// slots 1, 4 and 6 of each eight start a 32-bit instruction
		// and the one in slot 1 crosses into the next word
		kind = (h[3:1] == 3'd1 || h[3:1] == 3'd4 || h[3:1] == 3'd6) ? 2'b11 : {1'b0, h[1]};
		return {tag, kind};
	endfunction

	function automatic frontend_pkg::word_t word_at(input frontend_pkg::word_t a);
		return {half_at({a[31:2], 2'b10}), half_at({a[31:2], 2'b00})};
	endfunction

	function automatic logic in_err_range(input frontend_pkg::word_t a);
		return a >= err_lo && a < err_hi;
	endfunction

	// --------------------
	// checking

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic require(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("at %0t the check failed: %s", $time, what);
		end
	endtask

	// one clock cycle of memory and decode behaviour
	task automatic next_cycle;
		frontend_pkg::half_t head;
		int len;
		@(negedge clk);
		if (held) begin
			require(mem_addr_vld && mem_addr == held_addr, "a held address changed");
		end
		s_rst = rst_n;
		s_addr = mem_addr;
		s_addr_vld = mem_addr_vld;
		s_rdy = mem_addr_rdy;
		s_data_vld = mem_data_vld;
		held = rst_n && mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		@(posedge clk);
		#1;
		// a completing data phase and a new address can share one edge
		if (s_rst && s_data_vld) dphase_busy = 1'b0;
		if (s_rst && s_addr_vld && s_rdy) begin
			dphase_busy = 1'b1;
			dphase_addr = s_addr;
			rng = xorshift(rng);
			dphase_wait = (max_wait == 0) ? 0 : int'(rng % (max_wait + 1));
			if (!got_first) first_addr = s_addr;
			got_first = 1'b1;
		end
		// wait states hold the next address too
		mem_addr_rdy = !(dphase_busy && dphase_wait > 0);
		mem_data_vld = dphase_busy && dphase_wait == 0;
		mem_data = mem_data_vld ? word_at(dphase_addr) : 32'h0;
		mem_data_err = mem_data_vld && in_err_range(dphase_addr);
		if (dphase_busy && dphase_wait > 0) dphase_wait--;
		// decode takes one instruction once all of its halfwords are in the CIR
		cir_use = 2'd0;
		if (decode_on) begin
			head = half_at(exp_pc);
			len = (head[1:0] == 2'b11) ? 2 : 1;
			rng = xorshift(rng);
			if (cir_vld >= len && !(stalls_on && rng[1:0] == 2'b00)) begin
				compare_value($sformatf("cir low half at %h", exp_pc), cir[15:0], head);
				compare_value($sformatf("cir_err[0] at %h", exp_pc), cir_err[0],
					in_err_range(exp_pc));
				if (len == 2) begin
					compare_value($sformatf("cir high half at %h", exp_pc), cir[31:16],
						half_at(exp_pc + 2));
					compare_value($sformatf("cir_err[1] at %h", exp_pc), cir_err[1],
						in_err_range(exp_pc + 2));
				end
				cir_use = frontend_pkg::level_t'(len);
				consumed++;
				exp_pc = redirect_pending ? redirect_pc : exp_pc + 2 * len;
				redirect_pending = 1'b0;
			end
		end
	endtask

	task automatic run_instrs(input int n);
		int target;
		target = consumed + n;
		while (consumed < target) next_cycle();
	endtask

	// decode idles in the jump cycle, as the jump comes from its oldest instruction
	task automatic take_jump(input frontend_pkg::word_t dest, input logic fb);
		frontend_pkg::half_t head;
		int len;
		decode_on = 1'b0;
		next_cycle();
		head = half_at(exp_pc);
		len = (head[1:0] == 2'b11) ? 2 : 1;
		while (!jump_target_rdy || (fb && cir_vld < len)) next_cycle();
		jump_target = dest;
		jump_target_vld = 1'b1;
		cir_flush_behind = fb;
		next_cycle();
		compare_value("mem_addr in the jump cycle", s_addr, {dest[31:2], 2'b00});
		jump_target_vld = 1'b0;
		cir_flush_behind = 1'b0;
		compare_value("cir_vld after the jump", cir_vld, fb ? len : 0);
		if (fb) begin
			redirect_pending = 1'b1;
			redirect_pc = dest;
		end else begin
			exp_pc = dest;
		end
		decode_on = 1'b1;
	endtask

	// --------------------
	// directed tests

	task automatic reset_and_first_fetch;
		repeat (5) begin
			next_cycle();
			compare_value("cir_vld in reset", cir_vld, 0);
			compare_value("cir_err in reset", cir_err, 0);
			compare_value("mem_addr in reset", s_addr, reset_vector);
			compare_value("mem_addr_vld in reset", s_addr_vld, 1);
			compare_value("jump_target_rdy in reset", jump_target_rdy, 1);
		end
		rst_n = 1'b1;
		while (!got_first) next_cycle();
		compare_value("first accepted address", first_addr, reset_vector);
	endtask

	task automatic sequential_stream;
		exp_pc = reset_vector;
		decode_on = 1'b1;
		run_instrs(40);
	endtask

	task automatic waits_and_stalls;
		max_wait = 3;
		stalls_on = 1'b1;
		run_instrs(60);
		max_wait = 0;
		stalls_on = 1'b0;
	endtask

	task automatic halfword_jump;
		take_jump(32'h0000_0106, 1'b0);
		run_instrs(20);
	endtask

	task automatic error_range;
		take_jump(32'h0000_02fa, 1'b0);
		run_instrs(20);
	endtask

	task automatic flush_behind_jump;
		take_jump(32'h0000_0482, 1'b1);
		run_instrs(12);
		take_jump(32'h0000_0510, 1'b1);
		run_instrs(12);
	endtask

	initial begin
		rst_n = 1'b0;
		mem_addr_rdy = 1'b1;
		mem_data = 32'h0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target = 32'h0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		cir_flush_behind = 1'b0;
		errors = 0;
		checks = 0;
		rng = 32'd12618;
		dphase_busy = 1'b0;
		dphase_wait = 0;
		max_wait = 0;
		held = 1'b0;
		got_first = 1'b0;
		decode_on = 1'b0;
		stalls_on = 1'b0;
		redirect_pending = 1'b0;
		consumed = 0;
		reset_and_first_fetch();
		sequential_stream();
		waits_and_stalls();
		halfword_jump();
		error_range();
		flush_behind_jump();
		prop_fails = dut0.fetch_request0.props0.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		wait (cycle_count >= cycle_limit);
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("tests failed");
		$finish;
	end

endmodule

/* src.f */
logic/frontend_pkg.sv
logic/fetch_request.sv
logic/prefetch_queue.sv
logic/instr_assembly.sv
logic/frontend_top.sv
sim/frontend_properties.sv
sim/frontend_tb.sv
